/* verilog/dmem_params.svh */
// Width, depth and base address macros for the data memory subsystem
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// Bus widths
`define DMEM_DATA_W 64
`define DMEM_ADDR_W 32
`define DMEM_STRB_W (`DMEM_DATA_W / 8)

// Data SRAM window, depth counted in 64-bit words
`define DMEM_DEPTH 512
`define DMEM_BASE 32'h8000_0000

`endif

/* verilog/axil_pkg.sv */
// AXI-lite response codes, protection field type and default protection value
package axil_pkg;

  // Response codes, EXOKAY is not used by a lite slave
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // Protection bits {instruction, non-secure, privileged}
  typedef logic [2:0] prot_t;

  // Unprivileged secure data access
  localparam prot_t PROT_DATA = 3'b000;

endpackage

/* verilog/lsu_pkg.sv */
// Load/store operation encoding and access size type
package lsu_pkg;

  // Bit 3 store, bit 2 unsigned load, bits 1:0 log2 of the byte count
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LD  = 4'b0011,
    LBU = 4'b0100,
    LHU = 4'b0101,
    LWU = 4'b0110,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010,
    SD  = 4'b1011
  } mem_op_t;

  // Access size as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_t;

endpackage

/* verilog/lsu_req_stage.sv */
// Request stage: op decode, alignment check, strobe and store data lane shift
`include "dmem_params.svh"

module lsu_req_stage (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,
  // Core request
  input  logic                    i_req_valid,
  output logic                    o_req_ready,
  input  lsu_pkg::mem_op_t        i_req_op,
  input  logic [`DMEM_ADDR_W-1:0] i_req_addr,
  input  logic [`DMEM_DATA_W-1:0] i_req_wdata,
  // To master stage
  output logic                    o_s1_valid,
  input  logic                    i_s1_ready,
  output logic [`DMEM_ADDR_W-1:0] o_s1_addr,
  output logic [`DMEM_DATA_W-1:0] o_s1_wdata,
  output logic [`DMEM_STRB_W-1:0] o_s1_strb,
  output logic                    o_s1_is_store,
  output lsu_pkg::size_t          o_s1_size,
  output logic                    o_s1_signed,
  output logic [2:0]              o_s1_byte_off,
  output logic                    o_s1_misal
);

  logic                    valid_q;
  logic                    init_q;
  logic                    req_fire;
  logic                    op_known;
  logic                    misal;
  lsu_pkg::size_t          size;
  logic [2:0]              byte_off;
  logic [`DMEM_STRB_W-1:0] strb_base;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  assign size     = lsu_pkg::size_t'(i_req_op[1:0]);
  assign byte_off = i_req_addr[2:0];

  always_comb begin
    case (i_req_op)
      lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD,
      lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU,
      lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD: op_known = 1'b1;
      default: op_known = 1'b0;
    endcase
  end

  // Offset must be a multiple of the access size
  always_comb begin
    case (size)
      lsu_pkg::SIZE_B: begin
        misal     = 1'b0;
        strb_base = `DMEM_STRB_W'(8'h01);
      end
      lsu_pkg::SIZE_H: begin
        misal     = byte_off[0];
        strb_base = `DMEM_STRB_W'(8'h03);
      end
      lsu_pkg::SIZE_W: begin
        misal     = |byte_off[1:0];
        strb_base = `DMEM_STRB_W'(8'h0f);
      end
      default: begin
        misal     = |byte_off;
        strb_base = `DMEM_STRB_W'(8'hff);
      end
    endcase
  end

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  // Ready stays low for one cycle after reset
  assign o_req_ready = init_q && (!valid_q || i_s1_ready);
  assign req_fire    = i_req_valid && o_req_ready;
  assign o_s1_valid  = valid_q;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      init_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (req_fire) begin
        valid_q <= 1'b1;
      end else if (i_s1_ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (req_fire) begin
      o_s1_addr     <= {i_req_addr[`DMEM_ADDR_W-1:3], 3'b000};
      o_s1_wdata    <= i_req_wdata << {byte_off, 3'b000};
      o_s1_strb     <= strb_base << byte_off;
      o_s1_is_store <= i_req_op[3];
      o_s1_size     <= size;
      o_s1_signed   <= !i_req_op[3] && !i_req_op[2];
      o_s1_byte_off <= byte_off;
      o_s1_misal    <= misal;
    end
  end

  a_known_op: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    req_fire |-> op_known);

endmodule

/* verilog/lsu_axil_master.sv */
// AXI-lite master stage: one read or write per request, misaligned bypass
`include "dmem_params.svh"

module lsu_axil_master (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,
  // From request stage
  input  logic                    i_s1_valid,
  output logic                    o_s1_ready,
  input  logic [`DMEM_ADDR_W-1:0] i_s1_addr,
  input  logic [`DMEM_DATA_W-1:0] i_s1_wdata,
  input  logic [`DMEM_STRB_W-1:0] i_s1_strb,
  input  logic                    i_s1_is_store,
  input  lsu_pkg::size_t          i_s1_size,
  input  logic                    i_s1_signed,
  input  logic [2:0]              i_s1_byte_off,
  input  logic                    i_s1_misal,
  // AXI-lite master
  output logic                    o_awvalid,
  input  logic                    i_awready,
  output logic [`DMEM_ADDR_W-1:0] o_awaddr,
  output axil_pkg::prot_t         o_awprot,
  output logic                    o_wvalid,
  input  logic                    i_wready,
  output logic [`DMEM_DATA_W-1:0] o_wdata,
  output logic [`DMEM_STRB_W-1:0] o_wstrb,
  input  logic                    i_bvalid,
  output logic                    o_bready,
  input  axil_pkg::resp_t         i_bresp,
  output logic                    o_arvalid,
  input  logic                    i_arready,
  output logic [`DMEM_ADDR_W-1:0] o_araddr,
  output axil_pkg::prot_t         o_arprot,
  input  logic                    i_rvalid,
  output logic                    o_rready,
  input  logic [`DMEM_DATA_W-1:0] i_rdata,
  input  axil_pkg::resp_t         i_rresp,
  // To load alignment stage
  output logic                    o_s2_valid,
  input  logic                    i_s2_ready,
  output logic [`DMEM_DATA_W-1:0] o_s2_rdata,
  output axil_pkg::resp_t         o_s2_resp,
  output lsu_pkg::size_t          o_s2_size,
  output logic                    o_s2_signed,
  output logic [2:0]              o_s2_byte_off,
  output logic                    o_s2_is_store
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_WR_ISSUE, ST_WR_RESP, ST_RD_ISSUE, ST_RD_DATA, ST_HOLD
  } state_t;

  state_t                  state_q;
  logic                    aw_done_q;
  logic                    w_done_q;
  logic [`DMEM_ADDR_W-1:0] addr_q;
  logic [`DMEM_DATA_W-1:0] wdata_q;
  logic [`DMEM_STRB_W-1:0] strb_q;
  logic                    s1_fire;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;
  logic                    ar_fire;
  logic                    r_fire;

  assign o_s1_ready = (state_q == ST_IDLE);
  assign s1_fire    = i_s1_valid && o_s1_ready;
  assign aw_fire    = o_awvalid && i_awready;
  assign w_fire     = o_wvalid && i_wready;
  assign b_fire     = i_bvalid && o_bready;
  assign ar_fire    = o_arvalid && i_arready;
  assign r_fire     = i_rvalid && o_rready;

  // aw and w raised together, each dropped after its own handshake
  assign o_awvalid = (state_q == ST_WR_ISSUE) && !aw_done_q;
  assign o_wvalid  = (state_q == ST_WR_ISSUE) && !w_done_q;
  assign o_bready  = (state_q == ST_WR_RESP);
  assign o_arvalid = (state_q == ST_RD_ISSUE);
  assign o_rready  = (state_q == ST_RD_DATA);
  assign o_awaddr  = addr_q;
  assign o_araddr  = addr_q;
  assign o_wdata   = wdata_q;
  assign o_wstrb   = strb_q;
  assign o_awprot  = axil_pkg::PROT_DATA;
  assign o_arprot  = axil_pkg::PROT_DATA;
  assign o_s2_valid = (state_q == ST_HOLD);

  // ------------------------------------------------------------
  // Transfer FSM
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (s1_fire) begin
            if (i_s1_misal) begin
              state_q <= ST_HOLD;
            end else if (i_s1_is_store) begin
              state_q <= ST_WR_ISSUE;
            end else begin
              state_q <= ST_RD_ISSUE;
            end
          end
        end
        ST_WR_ISSUE: begin
          if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
            state_q   <= ST_WR_RESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_done_q || aw_fire;
            w_done_q  <= w_done_q || w_fire;
          end
        end
        ST_WR_RESP:  if (b_fire) state_q <= ST_HOLD;
        ST_RD_ISSUE: if (ar_fire) state_q <= ST_RD_DATA;
        ST_RD_DATA:  if (r_fire) state_q <= ST_HOLD;
        ST_HOLD:     if (i_s2_ready) state_q <= ST_IDLE;
        default:     state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload and collected response
  always_ff @(posedge i_aclk) begin
    if (s1_fire) begin
      addr_q        <= i_s1_addr;
      wdata_q       <= i_s1_wdata;
      strb_q        <= i_s1_strb;
      o_s2_is_store <= i_s1_is_store;
      o_s2_size     <= i_s1_size;
      o_s2_signed   <= i_s1_signed;
      o_s2_byte_off <= i_s1_byte_off;
      o_s2_rdata    <= '0;
      o_s2_resp     <= i_s1_misal ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
    if (b_fire) begin
      o_s2_resp <= i_bresp;
    end
    if (r_fire) begin
      o_s2_rdata <= i_rdata;
      o_s2_resp  <= i_rresp;
    end
  end

  a_aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));

endmodule

/* verilog/axil_data_sram.sv */
// AXI-lite data SRAM slave with separate read and write FSMs over a byte-write array
`include "dmem_params.svh"

module axil_data_sram #(
  parameter int DEPTH = `DMEM_DEPTH
) (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,
  // Write address channel
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [`DMEM_ADDR_W-1:0] i_awaddr,
  input  axil_pkg::prot_t         i_awprot,
  // Write data channel
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [`DMEM_DATA_W-1:0] i_wdata,
  input  logic [`DMEM_STRB_W-1:0] i_wstrb,
  // Write response channel
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output axil_pkg::resp_t         o_bresp,
  // Read address channel
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [`DMEM_ADDR_W-1:0] i_araddr,
  input  axil_pkg::prot_t         i_arprot,
  // Read data channel
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic [`DMEM_DATA_W-1:0] o_rdata,
  output axil_pkg::resp_t         o_rresp
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam logic [`DMEM_ADDR_W-1:0] WIN_BYTES = `DMEM_ADDR_W'(DEPTH * 8);

  typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} wstate_t;
  typedef enum logic [1:0] {R_IDLE, R_ADDR, R_READ, R_RESP} rstate_t;

  wstate_t                 wstate_q;
  rstate_t                 rstate_q;
  logic [`DMEM_DATA_W-1:0] mem [DEPTH];
  logic [`DMEM_ADDR_W-1:0] awaddr_q;
  logic [`DMEM_ADDR_W-1:0] araddr_q;
  logic [`DMEM_ADDR_W-1:0] aw_off;
  logic [`DMEM_ADDR_W-1:0] ar_off;
  logic                    aw_hit;
  logic                    ar_hit;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    ar_fire;

  assign o_awready = (wstate_q == W_ADDR);
  assign o_wready  = (wstate_q == W_DATA);
  assign o_bvalid  = (wstate_q == W_RESP);
  assign o_arready = (rstate_q == R_ADDR);
  assign o_rvalid  = (rstate_q == R_RESP);
  assign aw_fire   = i_awvalid && o_awready;
  assign w_fire    = i_wvalid && o_wready;
  assign ar_fire   = i_arvalid && o_arready;

  // Below the base the offset wraps to a large value, so one compare covers both ends
  assign aw_off = awaddr_q - `DMEM_BASE;
  assign ar_off = araddr_q - `DMEM_BASE;
  assign aw_hit = (aw_off < WIN_BYTES);
  assign ar_hit = (ar_off < WIN_BYTES);

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wstate_q <= W_IDLE;
    end else begin
      case (wstate_q)
        W_IDLE:  if (i_awvalid) wstate_q <= W_ADDR;
        W_ADDR:  if (aw_fire) wstate_q <= W_DATA;
        W_DATA:  if (w_fire) wstate_q <= W_RESP;
        W_RESP:  if (i_bready) wstate_q <= W_IDLE;
        default: wstate_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      awaddr_q <= i_awaddr;
    end
    if (w_fire) begin
      o_bresp <= aw_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_DECERR;
    end
  end

  // Byte lanes enabled by the strobe
  always_ff @(posedge i_aclk) begin
    if (w_fire && aw_hit) begin
      for (int i = 0; i < `DMEM_STRB_W; i++) begin
        if (i_wstrb[i]) begin
          mem[aw_off[IDX_W+2:3]][8*i +: 8] <= i_wdata[8*i +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rstate_q <= R_IDLE;
    end else begin
      case (rstate_q)
        R_IDLE:  if (i_arvalid) rstate_q <= R_ADDR;
        R_ADDR:  if (ar_fire) rstate_q <= R_READ;
        R_READ:  rstate_q <= R_RESP;
        R_RESP:  if (i_rready) rstate_q <= R_IDLE;
        default: rstate_q <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      araddr_q <= i_araddr;
    end
    if (rstate_q == R_READ) begin
      o_rdata <= ar_hit ? mem[ar_off[IDX_W+2:3]] : '0;
      o_rresp <= ar_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_DECERR;
    end
  end

  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

endmodule

/* verilog/lsu_load_align.sv */
// Load alignment stage: byte extraction, sign or zero extension, response register
`include "dmem_params.svh"

module lsu_load_align (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,
  // From master stage
  input  logic                    i_s2_valid,
  output logic                    o_s2_ready,
  input  logic [`DMEM_DATA_W-1:0] i_s2_rdata,
  input  axil_pkg::resp_t         i_s2_resp,
  input  lsu_pkg::size_t          i_s2_size,
  input  logic                    i_s2_signed,
  input  logic [2:0]              i_s2_byte_off,
  input  logic                    i_s2_is_store,
  // Core response
  output logic                    o_rsp_valid,
  input  logic                    i_rsp_ready,
  output logic [`DMEM_DATA_W-1:0] o_rsp_rdata,
  output logic                    o_rsp_err
);

  logic                    s2_fire;
  logic [`DMEM_DATA_W-1:0] shifted;
  logic [`DMEM_DATA_W-1:0] extended;

  assign o_s2_ready = !o_rsp_valid || i_rsp_ready;
  assign s2_fire    = i_s2_valid && o_s2_ready;

  // Addressed bytes moved down to lane 0
  assign shifted = i_s2_rdata >> {i_s2_byte_off, 3'b000};

  always_comb begin
    case (i_s2_size)
      lsu_pkg::SIZE_B:
        extended = {{(`DMEM_DATA_W-8){i_s2_signed & shifted[7]}}, shifted[7:0]};
      lsu_pkg::SIZE_H:
        extended = {{(`DMEM_DATA_W-16){i_s2_signed & shifted[15]}}, shifted[15:0]};
      lsu_pkg::SIZE_W:
        extended = {{(`DMEM_DATA_W-32){i_s2_signed & shifted[31]}}, shifted[31:0]};
      default:
        extended = shifted;
    endcase
    // Stores answer with zero data
    if (i_s2_is_store) begin
      extended = '0;
    end
  end

  // ------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      o_rsp_valid <= 1'b0;
    end else if (s2_fire) begin
      o_rsp_valid <= 1'b1;
    end else if (i_rsp_ready) begin
      o_rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (s2_fire) begin
      o_rsp_rdata <= extended;
      o_rsp_err   <= (i_s2_resp != axil_pkg::RESP_OKAY);
    end
  end

endmodule

/* verilog/dmem_top.sv */
// Data memory subsystem top: request stage, AXI-lite master, data SRAM, load alignment
`include "dmem_params.svh"

module dmem_top (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,
  // Core request
  input  logic                    i_req_valid,
  output logic                    o_req_ready,
  input  lsu_pkg::mem_op_t        i_req_op,
  input  logic [`DMEM_ADDR_W-1:0] i_req_addr,
  input  logic [`DMEM_DATA_W-1:0] i_req_wdata,
  // Core response
  output logic                    o_rsp_valid,
  input  logic                    i_rsp_ready,
  output logic [`DMEM_DATA_W-1:0] o_rsp_rdata,
  output logic                    o_rsp_err
);

  // Stage 1 to master
  logic                    s1_valid;
  logic                    s1_ready;
  logic [`DMEM_ADDR_W-1:0] s1_addr;
  logic [`DMEM_DATA_W-1:0] s1_wdata;
  logic [`DMEM_STRB_W-1:0] s1_strb;
  logic                    s1_is_store;
  lsu_pkg::size_t          s1_size;
  logic                    s1_signed;
  logic [2:0]              s1_byte_off;
  logic                    s1_misal;

  // AXI-lite bus
  logic                    awvalid;
  logic                    awready;
  logic [`DMEM_ADDR_W-1:0] awaddr;
  axil_pkg::prot_t         awprot;
  logic                    wvalid;
  logic                    wready;
  logic [`DMEM_DATA_W-1:0] wdata;
  logic [`DMEM_STRB_W-1:0] wstrb;
  logic                    bvalid;
  logic                    bready;
  axil_pkg::resp_t         bresp;
  logic                    arvalid;
  logic                    arready;
  logic [`DMEM_ADDR_W-1:0] araddr;
  axil_pkg::prot_t         arprot;
  logic                    rvalid;
  logic                    rready;
  logic [`DMEM_DATA_W-1:0] rdata;
  axil_pkg::resp_t         rresp;

  // Master to load alignment
  logic                    s2_valid;
  logic                    s2_ready;
  logic [`DMEM_DATA_W-1:0] s2_rdata;
  axil_pkg::resp_t         s2_resp;
  lsu_pkg::size_t          s2_size;
  logic                    s2_signed;
  logic [2:0]              s2_byte_off;
  logic                    s2_is_store;

  lsu_req_stage lsu_req_stage_inst (
    .i_aclk(i_aclk), .i_rst_n(i_rst_n),
    .i_req_valid(i_req_valid), .o_req_ready(o_req_ready), .i_req_op(i_req_op),
    .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata),
    .o_s1_valid(s1_valid), .i_s1_ready(s1_ready), .o_s1_addr(s1_addr),
    .o_s1_wdata(s1_wdata), .o_s1_strb(s1_strb), .o_s1_is_store(s1_is_store),
    .o_s1_size(s1_size), .o_s1_signed(s1_signed), .o_s1_byte_off(s1_byte_off),
    .o_s1_misal(s1_misal)
  );

  lsu_axil_master lsu_axil_master_inst (
    .i_aclk(i_aclk), .i_rst_n(i_rst_n),
    .i_s1_valid(s1_valid), .o_s1_ready(s1_ready), .i_s1_addr(s1_addr),
    .i_s1_wdata(s1_wdata), .i_s1_strb(s1_strb), .i_s1_is_store(s1_is_store),
    .i_s1_size(s1_size), .i_s1_signed(s1_signed), .i_s1_byte_off(s1_byte_off),
    .i_s1_misal(s1_misal),
    .o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr), .o_awprot(awprot),
    .o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
    .i_bvalid(bvalid), .o_bready(bready), .i_bresp(bresp),
    .o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr), .o_arprot(arprot),
    .i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata), .i_rresp(rresp),
    .o_s2_valid(s2_valid), .i_s2_ready(s2_ready), .o_s2_rdata(s2_rdata),
    .o_s2_resp(s2_resp), .o_s2_size(s2_size), .o_s2_signed(s2_signed),
    .o_s2_byte_off(s2_byte_off), .o_s2_is_store(s2_is_store)
  );

  axil_data_sram #(
    .DEPTH(`DMEM_DEPTH)
  ) axil_data_sram_inst (
    .i_aclk(i_aclk), .i_rst_n(i_rst_n),
    .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr), .i_awprot(awprot),
    .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
    .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
    .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr), .i_arprot(arprot),
    .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp)
  );

  lsu_load_align lsu_load_align_inst (
    .i_aclk(i_aclk), .i_rst_n(i_rst_n),
    .i_s2_valid(s2_valid), .o_s2_ready(s2_ready), .i_s2_rdata(s2_rdata),
    .i_s2_resp(s2_resp), .i_s2_size(s2_size), .i_s2_signed(s2_signed),
    .i_s2_byte_off(s2_byte_off), .i_s2_is_store(s2_is_store),
    .o_rsp_valid(o_rsp_valid), .i_rsp_ready(i_rsp_ready),
    .o_rsp_rdata(o_rsp_rdata), .o_rsp_err(o_rsp_err)
  );

endmodule

/* testbench/dmem_checker.sv */
// Response checker: shadow memory, reference access model, in-order compare, reset checks
`include "dmem_params.svh"

module dmem_checker (
  input  logic                    i_aclk,
  input  logic                    i_rst_n,
  input  logic [2:0]              i_phase,
  input  logic                    i_req_valid,
  input  logic                    i_req_ready,
  input  logic [3:0]              i_req_op,
  input  logic [`DMEM_ADDR_W-1:0] i_req_addr,
  input  logic [`DMEM_DATA_W-1:0] i_req_wdata,
  input  logic                    i_rsp_valid,
  input  logic                    i_rsp_ready,
  input  logic [`DMEM_DATA_W-1:0] i_rsp_rdata,
  input  logic                    i_rsp_err,
  output int                      o_req_count,
  output int                      o_rsp_count,
  output int                      o_data_errors,
  output int                      o_proto_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_W = $clog2(`DMEM_DEPTH);

  logic [`DMEM_DATA_W-1:0] shadow [`DMEM_DEPTH];
  logic [64:0]             exp_q [$];
  string                   name_q [$];
  logic [64:0]             exp_rsp;
  string                   exp_name;
  int                      req_count = 0;
  int                      rsp_count = 0;
  int                      data_errors = 0;
  int                      proto_errors = 0;
  int                      rst_cycles = 0;
  logic                    rst_d = 1'b0;
  logic                    hold_d = 1'b0;
  logic [`DMEM_DATA_W-1:0] rdata_d;
  logic                    err_d;

  assign o_req_count    = req_count;
  assign o_rsp_count    = rsp_count;
  assign o_data_errors  = data_errors;
  assign o_proto_errors = proto_errors;

  function automatic string phase_name(input logic [2:0] p);
    case (p)
      3'd1: return "init_stores";
      3'd2: return "aligned_mix";
      3'd3: return "partial_stores";
      3'd4: return "misaligned";
      3'd5: return "out_of_window";
      3'd6: return "backpressure";
      default: return "idle";
    endcase
  endfunction

  // Expected {err, rdata}; stores update the shadow copy
  function automatic logic [64:0] ref_access(input logic [3:0] op, input logic [31:0] addr,
                                             input logic [63:0] wdata);
    int          nbytes;
    int          off;
    logic [31:0] word_off;
    logic [IDX_W-1:0] idx;
    logic [63:0] word;
    logic [63:0] value;
    nbytes   = 1 << op[1:0];
    off      = int'(addr[2:0]);
    word_off = addr - `DMEM_BASE;
    idx      = word_off[IDX_W+2:3];
    if ((off % nbytes) != 0) begin
      return {1'b1, 64'd0};
    end
    if (addr < `DMEM_BASE || addr >= `DMEM_BASE + 32'(`DMEM_DEPTH * 8)) begin
      return {1'b1, 64'd0};
    end
    if (op[3]) begin
      for (int b = 0; b < nbytes; b++) begin
        shadow[idx][8*(off+b) +: 8] = wdata[8*b +: 8];
      end
      return {1'b0, 64'd0};
    end
    word  = shadow[idx];
    value = 64'd0;
    for (int b = 0; b < nbytes; b++) begin
      value[8*b +: 8] = word[8*(off+b) +: 8];
    end
    // Signed loads fill the upper bytes with the top bit
    if (!op[2] && nbytes < 8 && value[8*nbytes-1]) begin
      for (int b = nbytes; b < 8; b++) begin
        value[8*b +: 8] = 8'hff;
      end
    end
    return {1'b0, value};
  endfunction

  always @(posedge i_aclk) begin
    if (!i_rst_n) begin
      if (rst_cycles > 0 && (i_rsp_valid !== 1'b0 || i_req_ready !== 1'b0)) begin
        $display("Response valid or request ready was high during reset at %0t", $time);
        proto_errors++;
      end
      rst_cycles++;
    end else if (rst_d && (i_rsp_valid !== 1'b0 || i_req_ready !== 1'b0)) begin
      $display("Response valid or request ready was high right after reset at %0t", $time);
      proto_errors++;
    end
    if (i_rst_n && hold_d &&
        (i_rsp_valid !== 1'b1 || i_rsp_rdata !== rdata_d || i_rsp_err !== err_d)) begin
      $display("Response changed while the core was stalling it at %0t", $time);
      proto_errors++;
    end
    if (i_rst_n && i_req_valid && i_req_ready) begin
      exp_q.push_back(ref_access(i_req_op, i_req_addr, i_req_wdata));
      name_q.push_back(phase_name(i_phase));
      req_count++;
    end
    if (i_rst_n && i_rsp_valid && i_rsp_ready) begin
      rsp_count++;
      if (exp_q.size() == 0) begin
        $display("Response arrived with no request outstanding at %0t", $time);
        proto_errors++;
      end else begin
        exp_rsp  = exp_q.pop_front();
        exp_name = name_q.pop_front();
        if ({i_rsp_err, i_rsp_rdata} !== exp_rsp) begin
          $display("ERROR %s: expected err %0b data %h, actual err %0b data %h",
                   exp_name, exp_rsp[64], exp_rsp[63:0], i_rsp_err, i_rsp_rdata);
          data_errors++;
        end
      end
    end
    rst_d   = !i_rst_n;
    hold_d  = i_rst_n && i_rsp_valid && !i_rsp_ready;
    rdata_d = i_rsp_rdata;
    err_d   = i_rsp_err;
  end

endmodule

/* testbench/tb_dmem.sv */
// Testbench top: clock, reset, xorshift load/store stimulus, back-pressure and watchdog
`include "dmem_params.svh"

module tb_dmem;
  timeunit 1ns;
  timeprecision 1ps;

  // init 8, mix 150, partial 32, misaligned 24+8, window 16+8, back-pressure 200
  localparam int N_REQ          = 446;
  localparam int TIMEOUT_CYCLES = N_REQ * 40 + 200;

  logic                    aclk;
  logic                    rst_n;
  logic                    req_valid;
  logic                    req_ready;
  lsu_pkg::mem_op_t        req_op;
  logic [`DMEM_ADDR_W-1:0] req_addr;
  logic [`DMEM_DATA_W-1:0] req_wdata;
  logic                    rsp_valid;
  logic                    rsp_ready;
  logic [`DMEM_DATA_W-1:0] rsp_rdata;
  logic                    rsp_err;
  logic [2:0]              phase;
  logic                    bp_en;
  logic [31:0]             stim_state;
  logic [31:0]             bp_state;
  int                      req_count;
  int                      rsp_count;
  int                      data_errors;
  int                      proto_errors;
  lsu_pkg::mem_op_t        ops [11] = '{lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD,
                                        lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU, lsu_pkg::SB,
                                        lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD};

  dmem_top dmem_top_inst (
    .i_aclk(aclk), .i_rst_n(rst_n),
    .i_req_valid(req_valid), .o_req_ready(req_ready), .i_req_op(req_op),
    .i_req_addr(req_addr), .i_req_wdata(req_wdata),
    .o_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready),
    .o_rsp_rdata(rsp_rdata), .o_rsp_err(rsp_err)
  );

  dmem_checker dmem_checker_inst (
    .i_aclk(aclk), .i_rst_n(rst_n), .i_phase(phase),
    .i_req_valid(req_valid), .i_req_ready(req_ready), .i_req_op(req_op),
    .i_req_addr(req_addr), .i_req_wdata(req_wdata),
    .i_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready),
    .i_rsp_rdata(rsp_rdata), .i_rsp_err(rsp_err),
    .o_req_count(req_count), .o_rsp_count(rsp_count),
    .o_data_errors(data_errors), .o_proto_errors(proto_errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = xorshift(stim_state);
    return stim_state;
  endfunction

  // Eight test words spread from the first to the last word of the window
  function automatic logic [31:0] word_addr(input logic [2:0] k);
    return `DMEM_BASE + 32'(k) * 32'd584;
  endfunction

  // Called on a falling edge, returns on the falling edge after the handshake
  task automatic send_req(input lsu_pkg::mem_op_t op, input logic [31:0] addr,
                          input logic [63:0] wdata);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    // Ready comes from registers only and is settled here
    while (!req_ready) begin
      @(negedge aclk);
    end
    @(negedge aclk);
  endtask

  // Mode 0 aligned, 1 misaligned, 2 outside the window, 3 a mix of all three
  task automatic random_req(input logic [1:0] mode);
    logic [31:0]      r;
    logic [1:0]       m;
    logic [2:0]       off;
    logic [31:0]      addr;
    lsu_pkg::mem_op_t op;
    r = next_rand();
    m = mode;
    if (mode == 2'd3) begin
      m = (r[31:29] == 3'd0) ? 2'd1 : (r[31:29] == 3'd1) ? 2'd2 : 2'd0;
    end
    op = ops[r[7:4] % 4'd11];
    // A byte access is never misaligned
    if (m == 2'd1 && op[1:0] == 2'd0) begin
      op = lsu_pkg::mem_op_t'(op | 4'b0001);
    end
    off = r[14:12] & (3'b111 << op[1:0]);
    if (m == 2'd1) begin
      off = off | 3'b001;
    end
    addr = word_addr(r[10:8]);
    if (m == 2'd2) begin
      addr = r[15] ? (`DMEM_BASE - 32'd8 - {26'd0, r[10:8], 3'b000})
                   : (`DMEM_BASE + 32'(`DMEM_DEPTH * 8) + {26'd0, r[10:8], 3'b000});
    end
    send_req(op, addr + {29'd0, off}, {next_rand(), next_rand()});
  endtask

  task automatic read_back();
    for (int i = 0; i < 8; i++) begin
      send_req(lsu_pkg::LD, word_addr(3'(i)), 64'd0);
    end
  endtask

  initial begin
    aclk = 1'b0;
    forever begin
      #4 aclk = ~aclk;
    end
  end

  // Random response back-pressure once enabled
  initial begin
    forever begin
      @(negedge aclk);
      if (bp_en) begin
        bp_state  = xorshift(bp_state);
        rsp_ready = bp_state[16];
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge aclk);
    $display("Timeout: not all %0d responses arrived within %0d cycles", N_REQ, TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_op     = lsu_pkg::LD;
    req_addr   = '0;
    req_wdata  = '0;
    rsp_ready  = 1'b1;
    phase      = 3'd0;
    bp_en      = 1'b0;
    stim_state = 32'h4b70;
    bp_state   = 32'h4b70;
    repeat (5) @(negedge aclk);
    rst_n = 1'b1;
    phase = 3'd1;
    for (int i = 0; i < 8; i++) begin
      send_req(lsu_pkg::SD, word_addr(3'(i)), {next_rand(), next_rand()});
    end
    phase = 3'd2;
    repeat (150) random_req(2'd0);
    // Byte and halfword stores, each checked by a full word load
    phase = 3'd3;
    for (int i = 0; i < 8; i++) begin
      send_req(lsu_pkg::SB, word_addr(3'(i)) + 32'(i), {2{next_rand()}});
      send_req(lsu_pkg::LD, word_addr(3'(i)), 64'd0);
      send_req(lsu_pkg::SH, word_addr(3'(i)) + 32'(2 * (i % 4)), {2{next_rand()}});
      send_req(lsu_pkg::LD, word_addr(3'(i)), 64'd0);
    end
    phase = 3'd4;
    repeat (24) random_req(2'd1);
    read_back();
    phase = 3'd5;
    repeat (16) random_req(2'd2);
    read_back();
    phase = 3'd6;
    bp_en = 1'b1;
    repeat (200) random_req(2'd3);
    req_valid = 1'b0;
    while (rsp_count != req_count) begin
      @(negedge aclk);
    end
    // Room for a duplicate response to show up
    repeat (20) @(negedge aclk);
    $display("Summary: %0d requests, %0d responses, %0d data errors, %0d protocol errors",
             req_count, rsp_count, data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0 && rsp_count == N_REQ) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/axil_pkg.sv
verilog/lsu_pkg.sv
verilog/lsu_req_stage.sv
verilog/lsu_axil_master.sv
verilog/axil_data_sram.sv
verilog/lsu_load_align.sv
verilog/dmem_top.sv
testbench/dmem_checker.sv
testbench/tb_dmem.sv

/* Makefile */
TOP = tb_dmem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f flist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "test passed" > /dev/null

clean:
	rm -rf obj_dir
